/* run.sh */
#!/usr/bin/env bash
# Compile the noise estimator testbench with Verilator and run it.
# The exit status is the simulator's, nonzero on any failure.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
	-f src.f --top-module noise_est_tb -o noise_est_sim &&
./obj_dir/noise_est_sim || {
	echo "noise_est_tb build or run failed"
	exit 1
}

/* src.f */
src/frame_geom_pkg.sv
src/pix_rd_pkg.sv
src/frame_buffer.sv
src/block_reader.sv
src/noise_estimator.sv
src/noise_est_top.sv
verif/noise_est_tb.sv

/* src/block_reader.sv */
// Walks a frame held in the frame buffer block by block, left to right and
// top to bottom. Each 8x8 block is fetched as eight row bursts. The reader
// also frames the pixel stream for the noise estimator with start_of_frame
// and noise_estimation_en, then waits for the estimate before going idle.
// Start a frame by pulsing frame_ready while the reader is idle.

`timescale 1ns/1ps
`default_nettype none

module block_reader import frame_geom_pkg::*, pix_rd_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	input  logic [dim_w-1:0]  frame_width,
	input  logic [dim_w-1:0]  frame_height,
	input  logic              frame_ready,
	input  logic [addr_w-1:0] base_addr_in,
	input  logic              rvalid,
	input  logic              rlast,
	input  logic              estimated_noise_ready,
	output logic              start_read,
	output logic [addr_w-1:0] read_addr,
	output logic [addr_w-1:0] base_addr_out,
	output logic              noise_estimation_en,
	output logic              start_of_frame
);

	typedef enum logic [1:0] {
		IDLE,
		READ_HANDSHAKE,
		READ,
		FRAME_READY
	} state_t;

	state_t state, next_state;

	logic [dim_w-1:0]      cols_num;
	logic [dim_w-1:0]      rows_num;
	logic [dim_w-1:0]      blk_col;
	logic [dim_w-1:0]      blk_row;
	logic [block_log2-1:0] in_row;   // row inside the current block
	logic [dim_w-1:0]      nxt_col;
	logic [dim_w-1:0]      nxt_row;
	logic [block_log2-1:0] nxt_in_row;
	logic [dim_w-1:0]      nxt_line;  // frame line of the next burst
	logic                  last_in;
	logic                  last_col;
	logic                  last_row;
	logic                  last_burst;
	logic                  launch_first;
	logic [rd_latency-1:0] sof_pipe;
	logic [addr_w-1:0]     cur_base;
	logic [addr_w-1:0]     addr_hold;

	assign cols_num = frame_width >> block_log2;
	assign rows_num = frame_height >> block_log2;

	assign last_in    = (in_row == block_log2'(block_size - 1));
	assign last_col   = (blk_col == cols_num - 1'b1);
	assign last_row   = (blk_row == rows_num - 1'b1);
	assign last_burst = last_in && last_col && last_row;

	// counters for the burst after the current one, wrapping at frame end
	assign nxt_in_row = in_row + 1'b1;
	assign nxt_col    = !last_in ? blk_col : (last_col ? '0 : blk_col + 1'b1);
	assign nxt_row    = !(last_in && last_col) ? blk_row :
	                    (last_row ? '0 : blk_row + 1'b1);
	assign nxt_line   = (nxt_row << block_log2) + nxt_in_row;

	// all counters sit at zero only while the first burst is issued
	assign launch_first = start_read && blk_col == '0 && blk_row == '0 && in_row == '0;

	// first beat shows up rd_latency cycles after its start_read
	assign start_of_frame = sof_pipe[rd_latency-1];

	always_comb begin
		next_state = state;
		case (state)
			IDLE:
				if (frame_ready)
					next_state = READ_HANDSHAKE;
			READ_HANDSHAKE:
				if (rvalid)
					next_state = READ;
			READ:
				if (rlast)
					next_state = last_burst ? FRAME_READY : READ_HANDSHAKE;
			FRAME_READY:
				if (estimated_noise_ready)
					next_state = IDLE;
			default:
				next_state = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state               <= IDLE;
			start_read          <= 1'b0;
			blk_col             <= '0;
			blk_row             <= '0;
			in_row              <= '0;
			sof_pipe            <= '0;
			noise_estimation_en <= 1'b0;
		end else begin
			state      <= next_state;
			start_read <= 1'b0;  // single-cycle pulse
			sof_pipe   <= {sof_pipe[rd_latency-2:0], launch_first};

			case (state)
				IDLE: begin
					blk_col <= '0;
					blk_row <= '0;
					in_row  <= '0;
					if (frame_ready)
						start_read <= 1'b1;
				end
				READ: begin
					if (rlast) begin
						blk_col <= nxt_col;
						blk_row <= nxt_row;
						in_row  <= nxt_in_row;
						if (!last_burst)
							start_read <= 1'b1;  // one cycle after rlast
					end
				end
				default: ;
			endcase

			// enable spans first beat through the final rlast
			if (sof_pipe[rd_latency-2])
				noise_estimation_en <= 1'b1;
			else if (state == READ && rlast && last_burst)
				noise_estimation_en <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (state == IDLE && frame_ready) begin
			cur_base  <= base_addr_in;
			read_addr <= base_addr_in;
		end else if (state == READ && rlast) begin
			read_addr <= addr_hold;
		end

		// the multiply gets a full cycle before the address is needed
		if (state == READ)
			addr_hold <= cur_base + (nxt_col << block_log2) + frame_width * nxt_line;

		if (state == FRAME_READY)
			base_addr_out <= cur_base;
	end

	a_no_start_in_burst: assert property (@(posedge clk) disable iff (!rst_n)
		(state == READ || state == FRAME_READY) |-> !start_read);

endmodule

`default_nettype wire

/* src/frame_buffer.sv */
// On-chip frame buffer. Pixels are loaded one per cycle through the write
// port. A start_read pulse launches an incrementing burst of burst_beats
// one-pixel beats, the first arriving rd_latency cycles after the pulse.
// Beats stream on consecutive cycles without back-pressure.

`timescale 1ns/1ps
`default_nettype none

module frame_buffer import frame_geom_pkg::*, pix_rd_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              wr_en,
	input  logic [addr_w-1:0] wr_addr,
	input  logic [pix_w-1:0]  wr_data,
	input  logic              start_read,
	input  logic [addr_w-1:0] read_addr,
	output logic              rvalid,
	output logic              rlast,
	output logic [pix_w-1:0]  rdata
);

	localparam int beat_w = $clog2(burst_beats);

	logic [pix_w-1:0]     mem [fb_depth];
	logic [fb_addr_w-1:0] rd_ptr;
	logic [beat_w-1:0]    beat;
	logic                 pend;   // address latched, first beat next
	logic                 fetch;  // read the array this cycle

	assign fetch = pend || (rvalid && !rlast);

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_addr[fb_addr_w-1:0]] <= wr_data;
	end

	// read pointer and data word
	always_ff @(posedge clk) begin
		if (start_read)
			rd_ptr <= read_addr[fb_addr_w-1:0];
		else if (fetch)
			rd_ptr <= rd_ptr + 1'b1;
		if (fetch)
			rdata <= mem[rd_ptr];
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pend   <= 1'b0;
			rvalid <= 1'b0;
			rlast  <= 1'b0;
			beat   <= '0;
		end else begin
			pend <= start_read;
			if (pend) begin
				rvalid <= 1'b1;
				rlast  <= 1'b0;
				beat   <= '0;
			end else if (rvalid) begin
				beat  <= beat + 1'b1;
				rlast <= (beat == beat_w'(burst_beats - 2)); // flag the final beat
				if (rlast)
					rvalid <= 1'b0;
			end
		end
	end

	// the reader waits for rlast before launching the next burst
	a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
		start_read |-> !pend && !rvalid);

endmodule

`default_nettype wire

/* src/frame_geom_pkg.sv */
// Block and frame geometry shared by the frame buffer, the block reader
// and the noise estimator. Pixels are unsigned 8-bit luma samples and
// blocks are square, so one edge size covers both directions.
// Import with a wildcard in the module header.

`default_nettype none

package frame_geom_pkg;

	// square block walked by the reader and scored by the estimator
	localparam int block_size   = 8;
	localparam int block_log2   = 3;   // log2 of block_size
	localparam int block_pixels = 64;  // block_size * block_size

	localparam int pix_w = 8;  // pixel sample width

	// frame_width and frame_height inputs, both multiples of block_size
	localparam int dim_w = 16;

	// 64 * sum(p^2) for a full block of 8-bit pixels needs 28 bits
	localparam int energy_w = 28;

endpackage

`default_nettype wire

/* src/noise_est_top.sv */
// Denoiser front end: frame buffer, block reader and noise estimator.
// Load pixels through the write port, set the frame size and base, then
// pulse frame_ready. noise_level and noise_frame_base are valid while
// noise_valid is high.

`timescale 1ns/1ps
`default_nettype none

module noise_est_top import frame_geom_pkg::*, pix_rd_pkg::*; (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                wr_en,
	input  logic [addr_w-1:0]   wr_addr,
	input  logic [pix_w-1:0]    wr_data,
	input  logic                frame_ready,
	input  logic [dim_w-1:0]    frame_width,
	input  logic [dim_w-1:0]    frame_height,
	input  logic [addr_w-1:0]   base_addr_in,
	output logic [energy_w-1:0] noise_level,
	output logic                noise_valid,
	output logic [addr_w-1:0]   noise_frame_base
);

	logic              start_read;
	logic [addr_w-1:0] read_addr;
	logic              rvalid;
	logic              rlast;
	logic [pix_w-1:0]  rdata;
	logic              noise_estimation_en;
	logic              start_of_frame;
	logic              estimated_noise_ready;

	frame_buffer u_buf (
		.clk, .rst_n, .wr_en, .wr_addr, .wr_data,
		.start_read, .read_addr, .rvalid, .rlast, .rdata
	);

	block_reader u_rdr (
		.clk, .rst_n, .frame_width, .frame_height, .frame_ready, .base_addr_in,
		.rvalid, .rlast, .estimated_noise_ready, .start_read, .read_addr,
		.base_addr_out(noise_frame_base), .noise_estimation_en, .start_of_frame
	);

	noise_estimator u_est (
		.clk, .rst_n, .rvalid, .rdata, .noise_estimation_en, .start_of_frame,
		.noise_level, .noise_valid, .estimated_noise_ready
	);

endmodule

`default_nettype wire

/* src/noise_estimator.sv */
// Block energy noise estimator. For every 64 accepted beats it forms
// 64*sum(p^2) - sum(p)^2, which is 4096 times the block variance, and keeps
// the smallest value seen since start_of_frame. When noise_estimation_en
// falls, the minimum is published as noise_level with a one-cycle
// noise_valid, also sent back to the reader as estimated_noise_ready.

`timescale 1ns/1ps
`default_nettype none

module noise_estimator import frame_geom_pkg::*; (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                rvalid,
	input  logic [pix_w-1:0]    rdata,
	input  logic                noise_estimation_en,
	input  logic                start_of_frame,
	output logic [energy_w-1:0] noise_level,
	output logic                noise_valid,
	output logic                estimated_noise_ready
);

	localparam int cnt_w = $clog2(block_pixels);
	localparam int sum_w = pix_w + cnt_w;
	localparam int sq_w  = 2 * pix_w + cnt_w;

	logic [cnt_w-1:0]    beat_cnt;
	logic [sum_w-1:0]    sum_p;
	logic [sq_w-1:0]     sum_sq;
	logic [sum_w-1:0]    tot_sum;     // sums including the current beat
	logic [sq_w-1:0]     tot_sq;
	logic [energy_w-1:0] sq_of_sum;
	logic [energy_w-1:0] energy;      // stage 1 result
	logic [energy_w-1:0] min_energy;
	logic                beat_ok;
	logic                block_done;
	logic                e_vld;
	logic                en_q;
	logic                fin_d;

	assign beat_ok    = rvalid && noise_estimation_en;
	assign block_done = beat_ok && (beat_cnt == cnt_w'(block_pixels - 1));

	assign tot_sum   = sum_p + rdata;
	assign tot_sq    = sum_sq + rdata * rdata;
	assign sq_of_sum = tot_sum * tot_sum;

	assign estimated_noise_ready = noise_valid;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			beat_cnt    <= '0;
			sum_p       <= '0;
			sum_sq      <= '0;
			e_vld       <= 1'b0;
			min_energy  <= '1;
			en_q        <= 1'b0;
			fin_d       <= 1'b0;
			noise_valid <= 1'b0;
		end else begin
			en_q        <= noise_estimation_en;
			fin_d       <= en_q && !noise_estimation_en;  // enable just fell
			noise_valid <= fin_d;
			e_vld       <= block_done;

			if (beat_ok) begin
				if (block_done) begin
					beat_cnt <= '0;  // next block starts clean
					sum_p    <= '0;
					sum_sq   <= '0;
				end else begin
					beat_cnt <= beat_cnt + 1'b1;
					sum_p    <= tot_sum;
					sum_sq   <= tot_sq;
				end
			end

			// stage 2 compares against the running minimum
			if (start_of_frame)
				min_energy <= '1;
			else if (e_vld && energy < min_energy)
				min_energy <= energy;
		end
	end

	always_ff @(posedge clk) begin
		if (block_done)
			energy <= (energy_w'(tot_sq) << cnt_w) - sq_of_sum;
		if (fin_d)
			noise_level <= min_energy;
	end

	// the reader only drops the enable after the final beat of a block
	a_whole_blocks: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(noise_estimation_en) |-> beat_cnt == '0);

endmodule

`default_nettype wire

/* src/pix_rd_pkg.sv */
// Pixel read path constants: addressing of the on-chip frame buffer and
// the shape and latency of its burst reads. All addresses count pixels.
// Import with a wildcard in the module header.

`default_nettype none

package pix_rd_pkg;

	localparam int addr_w    = 16;    // read_addr, base addresses
	localparam int fb_depth  = 8192;  // pixels held by the buffer
	localparam int fb_addr_w = 13;    // log2 of fb_depth

	// one burst covers one row of a block
	localparam int burst_beats = frame_geom_pkg::block_size;

	// start_read to first rvalid
	localparam int rd_latency = 2;

endpackage

`default_nettype wire

/* verif/noise_est_tb.sv */
// Testbench for the denoiser front end. Loads frames of pseudo-random pixels
// through the write port, mirrors them in a local array and runs the noise
// estimate over each frame. Concurrent assertions compare noise_level and
// noise_frame_base against a block energy model when noise_valid pulses.

`timescale 1ns/1ps
`default_nettype none

module noise_est_tb import frame_geom_pkg::*, pix_rd_pkg::*; ();

	localparam logic [31:0] seed = 32'h092e_fe3e;
	// about 700 load cycles plus 1200 walk cycles over all frames, with wide margin
	localparam int timeout_cycles = 20000;

	logic                clk;
	logic                rst_n;
	logic                wr_en;
	logic [addr_w-1:0]   wr_addr;
	logic [pix_w-1:0]    wr_data;
	logic                frame_ready;
	logic [dim_w-1:0]    frame_width;
	logic [dim_w-1:0]    frame_height;
	logic [addr_w-1:0]   base_addr_in;
	logic [energy_w-1:0] noise_level;
	logic                noise_valid;
	logic [addr_w-1:0]   noise_frame_base;

	logic [pix_w-1:0]    mirror [fb_depth];  // copy of what the buffer holds
	logic [31:0]         rng;
	logic [energy_w-1:0] exp_level;
	logic [addr_w-1:0]   exp_base;
	int                  frames_req = 0;
	int                  valid_seen = 0;
	int                  cycles = 0;

	noise_est_top dut (
		.clk, .rst_n, .wr_en, .wr_addr, .wr_data, .frame_ready,
		.frame_width, .frame_height, .base_addr_in,
		.noise_level, .noise_valid, .noise_frame_base
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		if (noise_valid)
			valid_seen <= valid_seen + 1;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == timeout_cycles) begin
			$display("timeout after %0d cycles, noise_valid never arrived", cycles);
			$display("SIMULATION FAILED");
			$fatal(1, "timeout");
		end
	end

	a_level: assert property (@(posedge clk) disable iff (!rst_n)
		noise_valid |-> noise_level == exp_level)
		else begin
			$display("ERROR noise_level got %h expected %h", $sampled(noise_level), exp_level);
			$display("SIMULATION FAILED");
			$fatal(1, "noise_level mismatch");
		end

	a_base: assert property (@(posedge clk) disable iff (!rst_n)
		noise_valid |-> noise_frame_base == exp_base)
		else begin
			$display("ERROR noise_frame_base got %h expected %h",
				$sampled(noise_frame_base), exp_base);
			$display("SIMULATION FAILED");
			$fatal(1, "noise_frame_base mismatch");
		end

	// one pulse per requested frame, none before the first request
	a_one_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		noise_valid |-> valid_seen < frames_req)
		else begin
			$display("noise_valid pulsed without a pending frame_ready");
			$display("SIMULATION FAILED");
			$fatal(1, "extra noise_valid");
		end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// lo_range keeps pixels in 0..3 for a low energy frame
	task automatic load_frame(input int base, input int w, input int h,
			input bit lo_range, input int const_blk);
		logic [pix_w-1:0] p;
		int blk;
		wr_en = 1'b1;
		for (int y = 0; y < h; y++) begin
			for (int x = 0; x < w; x++) begin
				blk = (y / block_size) * (w / block_size) + x / block_size;
				rng = xorshift32(rng);
				if (blk == const_blk)
					p = 8'h5a;  // flat block, zero energy
				else if (lo_range)
					p = {6'b0, rng[1:0]};
				else
					p = rng[7:0];
				wr_addr = addr_w'(base + y * w + x);
				wr_data = p;
				mirror[base + y * w + x] = p;
				@(posedge clk);
				#1;
			end
		end
		wr_en = 1'b0;
	endtask

	task automatic model_min(input int base, input int w, input int h,
			output logic [energy_w-1:0] result);
		longint s;
		longint sq;
		longint e;
		longint best;
		longint pix;
		best = 64'h7fff_ffff_ffff_ffff;
		for (int by = 0; by < h / block_size; by++) begin
			for (int bx = 0; bx < w / block_size; bx++) begin
				s  = 0;
				sq = 0;
				for (int r = 0; r < block_size; r++) begin
					for (int c = 0; c < block_size; c++) begin
						pix = mirror[base + (by * block_size + r) * w + bx * block_size + c];
						s  = s + pix;
						sq = sq + pix * pix;
					end
				end
				e = block_pixels * sq - s * s;  // 4096 times the variance
				if (e < best)
					best = e;
			end
		end
		result = best[energy_w-1:0];
	endtask

	task automatic run_frame(input int base, input int w, input int h);
		model_min(base, w, h, exp_level);
		exp_base     = addr_w'(base);
		frame_width  = dim_w'(w);
		frame_height = dim_w'(h);
		base_addr_in = addr_w'(base);
		frame_ready  = 1'b1;
		frames_req   = frames_req + 1;
		@(posedge clk);
		#1;
		frame_ready = 1'b0;
		while (valid_seen != frames_req) begin
			@(posedge clk);
			#1;
		end
		repeat (2) @(posedge clk);  // reader back in IDLE
		#1;
	endtask

	initial begin
		rng          = seed;
		rst_n        = 1'b0;
		wr_en        = 1'b0;
		wr_addr      = '0;
		wr_data      = '0;
		frame_ready  = 1'b0;
		frame_width  = '0;
		frame_height = '0;
		base_addr_in = '0;
		exp_level    = '0;
		exp_base     = '0;
		repeat (4) @(posedge clk);
		#1;
		rst_n = 1'b1;

		repeat (20) @(posedge clk);  // idle, no noise_valid expected
		#1;

		load_frame(0, 16, 16, 1'b0, -1);
		run_frame(0, 16, 16);

		// non-square walk with an offset base and the middle block flat
		load_frame(4096, 24, 8, 1'b0, 1);
		run_frame(4096, 24, 8);

		// low energy frame first, so a stale minimum would show in the second
		load_frame(1024, 16, 8, 1'b1, -1);
		load_frame(2048, 8, 16, 1'b0, -1);
		run_frame(1024, 16, 8);
		run_frame(2048, 8, 16);

		load_frame(6000, 8, 8, 1'b0, -1);
		run_frame(6000, 8, 8);

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire
